// File: Makefile
VERILATOR  ?= verilator
TOP        := tbExu
FILELIST   := exuCore.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
PASS_MSG   := No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: exuAlu.sv
`default_nettype none

module exuAlu (
    input  wire exuPkg::aluOpE      aluOp_i,
    input  wire exuPkg::aSrcE       aSrc_i,
    input  wire exuPkg::bSrcE       bSrc_i,
    input  wire                     isWord_i,
    input  wire [exuPkg::XLEN-1:0]  pc_i,
    input  wire [exuPkg::XLEN-1:0]  rs1_i,
    input  wire [exuPkg::XLEN-1:0]  rs2_i,
    input  wire [exuPkg::XLEN-1:0]  imm_i,
    output logic [exuPkg::XLEN-1:0] res_o,
    output logic                    less_o,
    output logic                    zero_o
);
    import exuPkg::*;

    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [5:0]      shamt;
    logic [XLEN-1:0] shSrcU;
    logic [XLEN-1:0] shSrcS;
    logic [XLEN-1:0] raw;

    // operand select
    assign opA = (aSrc_i == aSrcPc) ? pc_i : rs1_i;

    always_comb begin
        unique case (bSrc_i)
            bSrcRs2:  opB = rs2_i;
            bSrcImm:  opB = imm_i;
            bSrcFour: opB = XLEN'(4);
            default:  opB = '0;
        endcase
    end

    // word ops shift by 5 bits and only see the low half of the source
    assign shamt  = isWord_i ? {1'b0, opB[4:0]} : opB[5:0];
    assign shSrcU = isWord_i ? {32'd0, opA[31:0]} : opA;
    assign shSrcS = isWord_i ? {{32{opA[31]}}, opA[31:0]} : opA;

    always_comb begin
        unique case (aluOp_i)
            aluAdd:   raw = opA + opB;
            aluSub:   raw = opA - opB;
            aluSll:   raw = shSrcU << shamt;
            aluSlt:   raw = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            aluSltu:  raw = {{(XLEN-1){1'b0}}, opA < opB};
            aluXor:   raw = opA ^ opB;
            aluSrl:   raw = shSrcU >> shamt;
            aluSra:   raw = $signed(shSrcS) >>> shamt;
            aluOr:    raw = opA | opB;
            aluAnd:   raw = opA & opB;
            aluPassB: raw = opB;
            default:  raw = '0;
        endcase
    end

    // word result is sign extended from bit 31
    assign res_o = isWord_i ? {{32{raw[31]}}, raw[31:0]} : raw;

    // branch flags compare the registers directly, sltu picks the unsigned form
    assign less_o = (aluOp_i == aluSltu) ? (rs1_i < rs2_i)
                                         : ($signed(rs1_i) < $signed(rs2_i));
    assign zero_o = (rs1_i == rs2_i);

endmodule

`default_nettype wire

// File: exuBranch.sv
`default_nettype none

module exuBranch (
    input  wire exuPkg::branchOpE   branchOp_i,
    input  wire                     less_i,
    input  wire                     zero_i,
    input  wire [exuPkg::XLEN-1:0]  pc_i,
    input  wire [exuPkg::XLEN-1:0]  rs1_i,
    input  wire [exuPkg::XLEN-1:0]  imm_i,
    output exuPkg::redirectT        redirect_o
);
    import exuPkg::*;

    logic            taken;
    logic [XLEN-1:0] pcTarget;
    logic [XLEN-1:0] regSum;

    assign pcTarget = pc_i + imm_i;
    assign regSum   = rs1_i + imm_i;

    always_comb begin
        unique case (branchOp_i)
            brJal:   taken = 1'b1;
            brJalr:  taken = 1'b1;
            brBeq:   taken = zero_i;
            brBne:   taken = !zero_i;
            brBlt:   taken = less_i;
            brBge:   taken = !less_i;
            brBltu:  taken = less_i;
            brBgeu:  taken = !less_i;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        redirect_o.taken = taken;
        if (!taken) begin
            redirect_o.nextPc = pc_i + XLEN'(4);
        end else if (branchOp_i == brJalr) begin
            // jalr clears bit 0 of the target
            redirect_o.nextPc = {regSum[XLEN-1:1], 1'b0};
        end else begin
            redirect_o.nextPc = pcTarget;
        end
    end

endmodule

`default_nettype wire

// File: exuCore.f
exuPkg.sv
pipeReg.sv
exuAlu.sv
exuBranch.sv
exuStage.sv
exuSubsys.sv
tbExu.sv

// File: exuPkg.sv
`default_nettype none

package exuPkg;

    localparam int XLEN = 64;
    localparam int ILEN = 32;

    typedef enum logic [3:0] {
        aluAdd   = 4'h0,
        aluSub   = 4'h1,
        aluSll   = 4'h2,
        aluSlt   = 4'h3,
        aluSltu  = 4'h4,
        aluXor   = 4'h5,
        aluSrl   = 4'h6,
        aluSra   = 4'h7,
        aluOr    = 4'h8,
        aluAnd   = 4'h9,
        aluPassB = 4'ha
    } aluOpE;

    typedef enum logic {
        aSrcRs1 = 1'b0,
        aSrcPc  = 1'b1
    } aSrcE;

    typedef enum logic [1:0] {
        bSrcRs2  = 2'd0,
        bSrcImm  = 2'd1,
        bSrcFour = 2'd2
    } bSrcE;

    typedef enum logic [3:0] {
        brNone = 4'h0,
        brJal  = 4'h1,
        brJalr = 4'h2,
        brBeq  = 4'h3,
        brBne  = 4'h4,
        brBlt  = 4'h5,
        brBge  = 4'h6,
        brBltu = 4'h7,
        brBgeu = 4'h8
    } branchOpE;

    // low two bits give the size code 0..3 for 1, 2, 4, 8 bytes, bit 3 marks a store
    typedef enum logic [3:0] {
        memLb   = 4'h0,
        memLh   = 4'h1,
        memLw   = 4'h2,
        memLd   = 4'h3,
        memLbu  = 4'h4,
        memLhu  = 4'h5,
        memLwu  = 4'h6,
        memNone = 4'h7,
        memSb   = 4'h8,
        memSh   = 4'h9,
        memSw   = 4'ha,
        memSd   = 4'hb
    } memOpE;

    typedef struct packed {
        aluOpE            aluOp;
        aSrcE             aSrc;
        bSrcE             bSrc;
        logic             isWord;
        branchOpE         branchOp;
        memOpE            memOp;
        logic             regWr;
        logic [1:0]       regSrc;
        logic [XLEN-1:0]  rs1Val;
        logic [XLEN-1:0]  rs2Val;
        logic [XLEN-1:0]  imm;
        logic [XLEN-1:0]  pc;
        logic [ILEN-1:0]  inst;
    } idExT;

    typedef struct packed {
        logic [XLEN-1:0]  aluRes;
        logic [XLEN-1:0]  storeData;
        memOpE            memOp;
        logic             regWr;
        logic [1:0]       regSrc;
        logic [XLEN-1:0]  pc;
        logic [ILEN-1:0]  inst;
    } exLsT;

    typedef struct packed {
        logic             op;
        logic [1:0]       size;
        logic [XLEN-1:0]  addr;
        logic [XLEN-1:0]  wdata;
        logic [7:0]       wstrb;
    } dcacheReqT;

    typedef struct packed {
        logic             taken;
        logic [XLEN-1:0]  nextPc;
    } redirectT;

endpackage

`default_nettype wire

// File: exuStage.sv
`default_nettype none

module exuStage (
    input  wire                    valid_i,
    input  wire exuPkg::idExT      data_i,
    output logic                   ready_o,
    output logic                   valid_o,
    output exuPkg::exLsT           data_o,
    input  wire                    ready_i,
    output logic                   dcReq_o,
    output exuPkg::dcacheReqT      dcReqData_o,
    input  wire                    dcReady_i,
    output exuPkg::redirectT       redirect_o
);
    import exuPkg::*;

    logic [XLEN-1:0] aluRes;
    logic            less;
    logic            zero;
    redirectT        brRedirect;
    logic            go;

    exuAlu alu0 (
        .aluOp_i  (data_i.aluOp),
        .aSrc_i   (data_i.aSrc),
        .bSrc_i   (data_i.bSrc),
        .isWord_i (data_i.isWord),
        .pc_i     (data_i.pc),
        .rs1_i    (data_i.rs1Val),
        .rs2_i    (data_i.rs2Val),
        .imm_i    (data_i.imm),
        .res_o    (aluRes),
        .less_o   (less),
        .zero_o   (zero)
    );

    exuBranch branch0 (
        .branchOp_i (data_i.branchOp),
        .less_i     (less),
        .zero_i     (zero),
        .pc_i       (data_i.pc),
        .rs1_i      (data_i.rs1Val),
        .imm_i      (data_i.imm),
        .redirect_o (brRedirect)
    );

    // a memory op may only leave once the cache took it
    assign dcReq_o = valid_i && (data_i.memOp != memNone);
    assign go      = !dcReq_o || dcReady_i;
    assign valid_o = valid_i && go;
    assign ready_o = !valid_i || (go && ready_i);

    // cache request
    always_comb begin
        dcReqData_o.op    = data_i.memOp[3];
        dcReqData_o.size  = data_i.memOp[1:0];
        dcReqData_o.addr  = aluRes;
        dcReqData_o.wdata = data_i.rs2Val;
        case (data_i.memOp[1:0])
            2'd0:    dcReqData_o.wstrb = 8'b0000_0001;
            2'd1:    dcReqData_o.wstrb = 8'b0000_0011;
            2'd2:    dcReqData_o.wstrb = 8'b0000_1111;
            default: dcReqData_o.wstrb = 8'b1111_1111;
        endcase
    end

    // redirect only as the instruction moves on
    always_comb begin
        redirect_o.taken  = brRedirect.taken && valid_o && ready_i;
        redirect_o.nextPc = brRedirect.nextPc;
    end

    always_comb begin
        data_o.aluRes    = aluRes;
        data_o.storeData = data_i.rs2Val;
        data_o.memOp     = data_i.memOp;
        data_o.regWr     = data_i.regWr;
        data_o.regSrc    = data_i.regSrc;
        data_o.pc        = data_i.pc;
        data_o.inst      = data_i.inst;
    end

    reqIsMem: assert final (!dcReq_o || (data_i.memOp inside {memLb, memLh, memLw, memLd,
                                                              memLbu, memLhu, memLwu,
                                                              memSb, memSh, memSw, memSd}))
        else $error("cache request raised without a defined memory op");

    redirectOnMove: assert final (!redirect_o.taken ||
                                  (valid_o && ready_i &&
                                   (data_i.branchOp inside {brJal, brJalr, brBeq, brBne,
                                                            brBlt, brBge, brBltu, brBgeu})))
        else $error("redirect taken without a branch leaving execute");

endmodule

`default_nettype wire

// File: exuStim.txt
// ctrl (aluOp aSrc bSrc isWord branchOp memOp regWr regSrc, one hex digit each) rs1 rs2 imm pc inst
// then expected: aluRes taken nextPc reqAddr reqStrb
00000710 5 7 0 1000 0 c 0 1004 0 0
10000710 3 5 0 1004 1 fffffffffffffffe 0 1008 0 0
00100710 100 0 fffffffffffffff0 1008 2 f0 0 100c 0 0
50000710 ff00 ff0 0 100c 3 f0f0 0 1010 0 0
20000710 1 3f 0 1010 4 8000000000000000 0 1014 0 0
60000710 8000000000000000 4 0 1014 5 0800000000000000 0 1018 0 0
70000710 8000000000000000 4 0 1018 6 f800000000000000 0 101c 0 0
30000710 ffffffffffffffff 1 0 101c 7 1 0 1020 0 0
40000710 ffffffffffffffff 1 0 1020 8 0 0 1024 0 0
a0100710 0 0 12345000 1024 9 12345000 0 1028 0 0
00010710 7fffffff 1 0 1028 a ffffffff80000000 0 102c 0 0
20010710 1 3f 0 102c b ffffffff80000000 0 1030 0 0
60010710 ffffffff80000000 4 0 1030 c 8000000 0 1034 0 0
70010710 80000000 4 0 1034 d fffffffff8000000 0 1038 0 0
10003700 5 5 40 1038 e 0 1 1078 0 0
10004700 5 5 40 103c f 0 0 1040 0 0
30005700 ffffffffffffffff 1 fffffffffffffff8 1040 10 1 1 1038 0 0
40008700 ffffffffffffffff 1 20 1044 11 0 1 1064 0 0
30006700 ffffffffffffffff 1 20 1048 12 1 0 104c 0 0
01201712 0 0 100 104c 13 1050 1 114c 0 0
01202712 2001 0 6 1050 14 1054 1 2006 0 0
00100311 8000 0 10 1054 15 8010 0 1058 8010 ff
00100800 9000 aa 3 1058 16 9003 0 105c 9003 1
00100900 9000 bbcc 2 105c 17 9002 0 1060 9002 3
00100a00 9000 11223344 4 1060 18 9004 0 1064 9004 f
00100b00 9000 0102030405060708 8 1064 19 9008 0 1068 9008 ff

// File: exuSubsys.sv
`default_nettype none

module exuSubsys (
    input  wire                    clk,
    input  wire                    rstN_i,
    input  wire                    inValid_i,
    input  wire exuPkg::idExT      inData_i,
    output logic                   inReady_o,
    output logic                   outValid_o,
    output exuPkg::exLsT           outData_o,
    input  wire                    outReady_i,
    output logic                   dcReq_o,
    output exuPkg::dcacheReqT      dcReqData_o,
    input  wire                    dcReady_i,
    output exuPkg::redirectT       redirect_o
);
    import exuPkg::*;

    logic idExValid;
    idExT idExData;
    logic idExReady;
    logic exValid;
    exLsT exData;
    logic exLsReady;

    pipeReg #(.payloadT(idExT)) idExReg (
        .clk     (clk),
        .rstN_i  (rstN_i),
        .valid_i (inValid_i),
        .data_i  (inData_i),
        .ready_o (inReady_o),
        .valid_o (idExValid),
        .data_o  (idExData),
        .ready_i (idExReady)
    );

    exuStage stage0 (
        .valid_i     (idExValid),
        .data_i      (idExData),
        .ready_o     (idExReady),
        .valid_o     (exValid),
        .data_o      (exData),
        .ready_i     (exLsReady),
        .dcReq_o     (dcReq_o),
        .dcReqData_o (dcReqData_o),
        .dcReady_i   (dcReady_i),
        .redirect_o  (redirect_o)
    );

    pipeReg #(.payloadT(exLsT)) exLsReg (
        .clk     (clk),
        .rstN_i  (rstN_i),
        .valid_i (exValid),
        .data_i  (exData),
        .ready_o (exLsReady),
        .valid_o (outValid_o),
        .data_o  (outData_o),
        .ready_i (outReady_i)
    );

endmodule

`default_nettype wire

// File: pipeReg.sv
`default_nettype none

module pipeReg #(
    parameter type payloadT = logic
) (
    input  wire          clk,
    input  wire          rstN_i,
    input  wire          valid_i,
    input  wire payloadT data_i,
    output logic         ready_o,
    output logic         valid_o,
    output payloadT      data_o,
    input  wire          ready_i
);

    logic    validQ;
    payloadT dataQ;

    // can take a new entry when empty or when the current one leaves
    assign ready_o = !validQ || ready_i;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            validQ <= 1'b0;
        end else if (ready_o) begin
            validQ <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i && ready_o) begin
            dataQ <= data_i;
        end
    end

    assign valid_o = validQ;
    assign data_o  = dataQ;

    // the sender keeps its payload until this register takes it
    holdWhileStalled: assert property (
        @(posedge clk) disable iff (!rstN_i)
        (valid_i && !ready_o) |=> $stable(data_i)
    ) else $error("incoming payload changed while stalled");

endmodule

`default_nettype wire

// File: tbExu.sv
`default_nettype none

module tbExu;
    timeunit 1ns;
    timeprecision 1ps;

    import exuPkg::*;

    localparam int vecWords = 11;
    localparam int maxVec   = 40;

    logic      clk;
    logic      rstN;
    logic      inValid;
    idExT      inData;
    logic      inReady;
    logic      outValid;
    exLsT      outData;
    logic      outReady;
    logic      dcReq;
    dcacheReqT dcReqData;
    logic      dcReady;
    redirectT  redirect;

    logic [XLEN-1:0] stimMem [0:maxVec*vecWords-1];
    int   numVec;
    int   errCount;
    int   outCount;
    int   reqCount;
    int   redirCount;
    int   seed;
    logic loaded;

    // expected results in issue order
    exLsT      exLsQ[$];
    dcacheReqT reqQ[$];
    redirectT  redirQ[$];

    exuSubsys dut0 (
        .clk         (clk),
        .rstN_i      (rstN),
        .inValid_i   (inValid),
        .inData_i    (inData),
        .inReady_o   (inReady),
        .outValid_o  (outValid),
        .outData_o   (outData),
        .outReady_i  (outReady),
        .dcReq_o     (dcReq),
        .dcReqData_o (dcReqData),
        .dcReady_i   (dcReady),
        .redirect_o  (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ctrl word holds one hex digit per control field
    function automatic idExT buildInstr(input int base);
        idExT            ins;
        logic [XLEN-1:0] ctrl;
        ctrl         = stimMem[base];
        ins.aluOp    = aluOpE'(ctrl[31:28]);
        ins.aSrc     = aSrcE'(ctrl[24]);
        ins.bSrc     = bSrcE'(ctrl[21:20]);
        ins.isWord   = ctrl[16];
        ins.branchOp = branchOpE'(ctrl[15:12]);
        ins.memOp    = memOpE'(ctrl[11:8]);
        ins.regWr    = ctrl[4];
        ins.regSrc   = ctrl[1:0];
        ins.rs1Val   = stimMem[base+1];
        ins.rs2Val   = stimMem[base+2];
        ins.imm      = stimMem[base+3];
        ins.pc       = stimMem[base+4];
        ins.inst     = stimMem[base+5][ILEN-1:0];
        return ins;
    endfunction

    task automatic queueExpected(input int base, input idExT ins);
        exLsT      expOut;
        dcacheReqT expReq;
        redirectT  expRedir;
        expOut.aluRes    = stimMem[base+6];
        expOut.storeData = ins.rs2Val;
        expOut.memOp     = ins.memOp;
        expOut.regWr     = ins.regWr;
        expOut.regSrc    = ins.regSrc;
        expOut.pc        = ins.pc;
        expOut.inst      = ins.inst;
        exLsQ.push_back(expOut);
        if (ins.memOp != memNone) begin
            expReq.op    = ins.memOp inside {memSb, memSh, memSw, memSd};
            expReq.size  = ins.memOp[1:0];
            expReq.addr  = stimMem[base+9];
            expReq.wdata = ins.rs2Val;
            expReq.wstrb = stimMem[base+10][7:0];
            reqQ.push_back(expReq);
        end
        if (stimMem[base+7][0]) begin
            expRedir.taken  = 1'b1;
            expRedir.nextPc = stimMem[base+8];
            redirQ.push_back(expRedir);
        end
    endtask

    task automatic checkExLs(input exLsT got, input exLsT exp);
        if (got !== exp) begin
            errCount++;
            $display("FAILED at %0t ns: inst %h aluRes %h expected %h, payload %h expected %h",
                     $time, exp.inst, got.aluRes, exp.aluRes, got, exp);
        end
    endtask

    task automatic checkCacheReq(input dcacheReqT got, input dcacheReqT exp);
        if (got !== exp) begin
            errCount++;
            $display("FAILED at %0t ns: request addr %h strb %h op %b, expected %h %h %b",
                     $time, got.addr, got.wstrb, got.op, exp.addr, exp.wstrb, exp.op);
        end
    endtask

    task automatic checkRedirect(input redirectT got, input redirectT exp);
        if (got !== exp) begin
            errCount++;
            $display("FAILED at %0t ns: redirect to %h, expected %h",
                     $time, got.nextPc, exp.nextPc);
        end
    endtask

    task automatic checkIdle();
        if (!inReady || outValid || dcReq || redirect.taken) begin
            errCount++;
            $display("FAILED at %0t ns: after reset inReady %b outValid %b dcReq %b redirect %b",
                     $time, inReady, outValid, dcReq, redirect.taken);
        end
    endtask

    task automatic driveVectors();
        idExT ins;
        for (int i = 0; i < numVec; i++) begin
            ins = buildInstr(i * vecWords);
            @(posedge clk);
            #1;
            inValid = 1'b1;
            inData  = ins;
            // handshake inputs are settled by the falling edge
            @(negedge clk);
            while (!inReady) @(negedge clk);
            queueExpected(i * vecWords, ins);
        end
        @(posedge clk);
        #1;
        inValid = 1'b0;
    endtask

    initial begin
        clk      = 1'b0;
        rstN     = 1'b0;
        inValid  = 1'b0;
        inData   = '0;
        outReady = 1'b0;
        dcReady  = 1'b0;
        errCount = 0;
        seed     = 32'haff8a006;
        loaded   = 1'b0;
        // upper half of all ones marks the end of the vectors
        for (int a = 0; a < maxVec * vecWords; a++) begin
            stimMem[a] = {32'hffff_ffff, 32'(a)};
        end
        $readmemh("exuStim.txt", stimMem);
        numVec = 0;
        while (numVec < maxVec && stimMem[numVec*vecWords][63:32] != 32'hffff_ffff) begin
            numVec++;
        end
        loaded = 1'b1;
        if (numVec == 0) begin
            errCount++;
            $display("No vectors could be read from exuStim.txt");
        end
        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;
        @(negedge clk);
        checkIdle();
        driveVectors();
        while (outCount < numVec) @(negedge clk);
        // a few idle cycles to catch anything extra
        repeat (5) @(negedge clk);
        if (reqQ.size() != 0) begin
            errCount++;
            $display("%0d cache requests were never accepted", reqQ.size());
        end
        if (redirQ.size() != 0) begin
            errCount++;
            $display("%0d redirects never appeared", redirQ.size());
        end
        $display("outputs %0d, requests %0d, redirects %0d, errors %0d",
                 outCount, reqCount, redirCount, errCount);
        if (errCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // random back-pressure from the memory stage and the cache
    initial begin
        wait (rstN);
        forever begin
            @(posedge clk);
            #1;
            outReady = ($random(seed) & 3) != 0;
            dcReady  = ($random(seed) & 3) != 0;
        end
    end

    initial begin
        outCount   = 0;
        reqCount   = 0;
        redirCount = 0;
        wait (rstN);
        forever begin
            @(negedge clk);
            if (outValid && outReady) begin
                if (exLsQ.size() == 0) begin
                    errCount++;
                    $display("Output at %0t ns with no instruction outstanding", $time);
                end else begin
                    checkExLs(outData, exLsQ[0]);
                    exLsQ.delete(0);
                end
                outCount++;
            end
            if (dcReq && dcReady) begin
                if (reqQ.size() == 0) begin
                    errCount++;
                    $display("Cache request at %0t ns from a non-memory instruction", $time);
                end else begin
                    checkCacheReq(dcReqData, reqQ[0]);
                    // repeats while exLsReg is full and stalled
                    if (!outValid || outReady) begin
                        reqQ.delete(0);
                        reqCount++;
                    end
                end
            end
            if (redirect.taken) begin
                if (redirQ.size() == 0) begin
                    errCount++;
                    $display("Redirect at %0t ns that no instruction should raise", $time);
                end else begin
                    checkRedirect(redirect, redirQ[0]);
                    redirQ.delete(0);
                end
                redirCount++;
            end
        end
    end

    initial begin
        wait (loaded);
        #((numVec * 40 + 10) * 10);
        $display("Timeout: the instructions did not all leave the pipeline in time");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
